// ==== common/bp_params_pkg.sv ====
package bp_params_pkg;

    // global history length
    // also the index width of all three pattern tables
    localparam int HISTORY_BITS = 6;

    localparam int PHT_SIZE = 64;   // entries per table, 2**HISTORY_BITS

    // two-bit saturating counters
    //   0, 1 : not taken
    //   2, 3 : taken
    // in the meta table the MSB picks gshare when set
    localparam int COUNTER_BITS = 2;
    localparam int COUNTER_MAX = 3;   // saturation ceiling, floor is 0

    // PCs are word aligned, so indexing skips the two low bits
    localparam int INDEX_LSB = 2;

endpackage

// ==== common/pipe_params_pkg.sv ====
package pipe_params_pkg;

    localparam int FETCH_WIDTH = 2;   // slots per fetch group
    localparam int PC_BITS = 32;

    // in-flight branch checkpoints
    localparam int STACK_DEPTH = 8;
    localparam int STACK_PTR_BITS = 3;   // log2 of STACK_DEPTH

endpackage

// ==== branch_predictor/branch_predictor.sv ====
`timescale 1ns/1ns

module branch_predictor
    import bp_params_pkg::*;
    import pipe_params_pkg::*;
(
    input  logic                                       clock,
    input  logic                                       reset,

    // fetch side
    input  logic                                       fetch_valid,
    input  logic [PC_BITS-1:0]                         fetch_pc,
    input  logic [FETCH_WIDTH-1:0]                     fetch_is_branch,
    input  logic                                       fetch_stall,
    input  logic                                       mispredict,

    // training from the resolver
    input  logic                                       update_valid,
    input  logic [HISTORY_BITS-1:0]                    update_simple_idx,
    input  logic [HISTORY_BITS-1:0]                    update_gshare_idx,
    input  logic [COUNTER_BITS-1:0]                    update_simple_state,
    input  logic [COUNTER_BITS-1:0]                    update_gshare_state,
    input  logic [COUNTER_BITS-1:0]                    update_meta_state,
    input  logic [HISTORY_BITS-1:0]                    repair_history,

    output logic [FETCH_WIDTH-1:0]                     predict_taken,

    // checkpoint records toward the branch stack
    output logic [FETCH_WIDTH-1:0]                     push,
    output logic [FETCH_WIDTH-1:0][HISTORY_BITS-1:0]   push_simple_idx,
    output logic [FETCH_WIDTH-1:0][HISTORY_BITS-1:0]   push_gshare_idx,
    output logic [FETCH_WIDTH-1:0][HISTORY_BITS-1:0]   push_history,
    output logic [FETCH_WIDTH-1:0][COUNTER_BITS-1:0]   push_simple_state,
    output logic [FETCH_WIDTH-1:0][COUNTER_BITS-1:0]   push_gshare_state,
    output logic [FETCH_WIDTH-1:0][COUNTER_BITS-1:0]   push_meta_state,
    output logic [FETCH_WIDTH-1:0]                     push_predicted
);

    // pattern tables, all indexed by HISTORY_BITS wide indices
    logic [COUNTER_BITS-1:0] simple_table [PHT_SIZE];
    logic [COUNTER_BITS-1:0] gshare_table [PHT_SIZE];
    logic [COUNTER_BITS-1:0] meta_table   [PHT_SIZE];   // indexed like the simple table

    logic [HISTORY_BITS-1:0] history;   // speculative global history

    // slot_history[i] is what slot i sees
    // the last entry is the history after the whole group
    logic [HISTORY_BITS-1:0] slot_history [FETCH_WIDTH+1];

    logic [PC_BITS-1:0]      slot_pc [FETCH_WIDTH];
    logic [FETCH_WIDTH-1:0]  recorded;   // branch that survives within the group
    logic                    fetch_accept;

    // a fetch is dropped while stalled or while a mispredict repairs state
    assign fetch_accept = fetch_valid && !fetch_stall && !mispredict;

    // table lookup, component choice and the speculative history chain
    always_comb begin
        logic blocked;   // an older slot in this group was predicted taken

        blocked = 1'b0;
        slot_history[0] = history;

        for (int i = 0; i < FETCH_WIDTH; i++) begin
            slot_pc[i] = fetch_pc + PC_BITS'(4 * i);

            push_simple_idx[i] = slot_pc[i][INDEX_LSB +: HISTORY_BITS];
            push_gshare_idx[i] = push_simple_idx[i] ^ slot_history[i];
            push_history[i]    = slot_history[i];

            push_simple_state[i] = simple_table[push_simple_idx[i]];
            push_gshare_state[i] = gshare_table[push_gshare_idx[i]];
            push_meta_state[i]   = meta_table[push_simple_idx[i]];

            // meta MSB set selects gshare
            if (push_meta_state[i][COUNTER_BITS-1]) begin
                push_predicted[i] = push_gshare_state[i][COUNTER_BITS-1];
            end else begin
                push_predicted[i] = push_simple_state[i][COUNTER_BITS-1];
            end

            recorded[i]      = fetch_is_branch[i] && !blocked;
            predict_taken[i] = recorded[i] && push_predicted[i];

            // only recorded branches shift their guess into the history
            if (recorded[i]) begin
                slot_history[i+1] = {slot_history[i][HISTORY_BITS-2:0], push_predicted[i]};
            end else begin
                slot_history[i+1] = slot_history[i];
            end

            blocked = blocked || predict_taken[i];   // later slots are off-path
        end
    end

    assign push = recorded & {FETCH_WIDTH{fetch_accept}};

    // history register, repair wins over a new group
    always_ff @(posedge clock) begin
        if (reset) begin
            history <= '0;
        end else if (mispredict) begin
            history <= repair_history;
        end else if (fetch_accept) begin
            history <= slot_history[FETCH_WIDTH];
        end
    end

    // counters start strongly not taken, written only by the resolver
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int e = 0; e < PHT_SIZE; e++) begin
                simple_table[e] <= '0;
                gshare_table[e] <= '0;
                meta_table[e]   <= '0;
            end
        end else if (update_valid) begin
            simple_table[update_simple_idx] <= update_simple_state;
            gshare_table[update_gshare_idx] <= update_gshare_state;
            meta_table[update_simple_idx]   <= update_meta_state;
        end
    end

endmodule

// ==== src/branch_stack.sv ====
`timescale 1ns/1ns

module branch_stack
    import bp_params_pkg::*;
    import pipe_params_pkg::*;
(
    input  logic                                       clock,
    input  logic                                       reset,

    input  logic [FETCH_WIDTH-1:0]                     push,
    input  logic [FETCH_WIDTH-1:0][HISTORY_BITS-1:0]   push_simple_idx,
    input  logic [FETCH_WIDTH-1:0][HISTORY_BITS-1:0]   push_gshare_idx,
    input  logic [FETCH_WIDTH-1:0][HISTORY_BITS-1:0]   push_history,
    input  logic [FETCH_WIDTH-1:0][COUNTER_BITS-1:0]   push_simple_state,
    input  logic [FETCH_WIDTH-1:0][COUNTER_BITS-1:0]   push_gshare_state,
    input  logic [FETCH_WIDTH-1:0][COUNTER_BITS-1:0]   push_meta_state,
    input  logic [FETCH_WIDTH-1:0]                     push_predicted,

    input  logic                                       pop,
    input  logic                                       mispredict,

    output logic                                       fetch_stall,
    output logic                                       stack_empty,

    // oldest in-flight record
    output logic [HISTORY_BITS-1:0]                    head_simple_idx,
    output logic [HISTORY_BITS-1:0]                    head_gshare_idx,
    output logic [HISTORY_BITS-1:0]                    head_history,
    output logic [COUNTER_BITS-1:0]                    head_simple_state,
    output logic [COUNTER_BITS-1:0]                    head_gshare_state,
    output logic [COUNTER_BITS-1:0]                    head_meta_state,
    output logic                                       head_predicted
);

    logic [HISTORY_BITS-1:0] simple_idx_mem   [STACK_DEPTH];
    logic [HISTORY_BITS-1:0] gshare_idx_mem   [STACK_DEPTH];
    logic [HISTORY_BITS-1:0] history_mem      [STACK_DEPTH];
    logic [COUNTER_BITS-1:0] simple_state_mem [STACK_DEPTH];
    logic [COUNTER_BITS-1:0] gshare_state_mem [STACK_DEPTH];
    logic [COUNTER_BITS-1:0] meta_state_mem   [STACK_DEPTH];
    logic                    predicted_mem    [STACK_DEPTH];

    logic [STACK_PTR_BITS-1:0] head;
    logic [STACK_PTR_BITS-1:0] tail;
    logic [STACK_PTR_BITS:0]   count;   // one extra bit to hold a full stack

    logic [STACK_PTR_BITS-1:0] write_ptr [FETCH_WIDTH];
    logic [STACK_PTR_BITS:0]   push_count;

    // pushing slots pack into consecutive entries in slot order
    always_comb begin
        push_count = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            write_ptr[i] = tail + push_count[STACK_PTR_BITS-1:0];   // wraps at depth
            push_count   = push_count + (STACK_PTR_BITS+1)'(push[i]);
        end
    end

    // stall unless a full group fits
    assign fetch_stall = count > (STACK_PTR_BITS+1)'(STACK_DEPTH - FETCH_WIDTH);
    assign stack_empty = count == '0;

    always_ff @(posedge clock) begin
        if (reset || mispredict) begin   // a mispredict drops every record
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + STACK_PTR_BITS'(pop);
            tail  <= tail + push_count[STACK_PTR_BITS-1:0];
            count <= count + push_count - (STACK_PTR_BITS+1)'(pop);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (push[i]) begin
                simple_idx_mem[write_ptr[i]]   <= push_simple_idx[i];
                gshare_idx_mem[write_ptr[i]]   <= push_gshare_idx[i];
                history_mem[write_ptr[i]]      <= push_history[i];
                simple_state_mem[write_ptr[i]] <= push_simple_state[i];
                gshare_state_mem[write_ptr[i]] <= push_gshare_state[i];
                meta_state_mem[write_ptr[i]]   <= push_meta_state[i];
                predicted_mem[write_ptr[i]]    <= push_predicted[i];
            end
        end
    end

    assign head_simple_idx   = simple_idx_mem[head];
    assign head_gshare_idx   = gshare_idx_mem[head];
    assign head_history      = history_mem[head];
    assign head_simple_state = simple_state_mem[head];
    assign head_gshare_state = gshare_state_mem[head];
    assign head_meta_state   = meta_state_mem[head];
    assign head_predicted    = predicted_mem[head];

endmodule

// ==== src/branch_resolver.sv ====
`timescale 1ns/1ns

module branch_resolver
    import bp_params_pkg::*;
(
    input  logic                     resolve_valid,
    input  logic                     resolve_taken,
    input  logic                     stack_empty,

    // oldest record from the stack
    input  logic [HISTORY_BITS-1:0]  head_simple_idx,
    input  logic [HISTORY_BITS-1:0]  head_gshare_idx,
    input  logic [HISTORY_BITS-1:0]  head_history,
    input  logic [COUNTER_BITS-1:0]  head_simple_state,
    input  logic [COUNTER_BITS-1:0]  head_gshare_state,
    input  logic [COUNTER_BITS-1:0]  head_meta_state,
    input  logic                     head_predicted,

    output logic                     pop,
    output logic                     mispredict,

    output logic                     update_valid,
    output logic [HISTORY_BITS-1:0]  update_simple_idx,
    output logic [HISTORY_BITS-1:0]  update_gshare_idx,
    output logic [COUNTER_BITS-1:0]  update_simple_state,
    output logic [COUNTER_BITS-1:0]  update_gshare_state,
    output logic [COUNTER_BITS-1:0]  update_meta_state,
    output logic [HISTORY_BITS-1:0]  repair_history
);

    logic simple_guess;
    logic gshare_guess;

    // one saturating step, up toward taken or down toward not taken
    function automatic logic [COUNTER_BITS-1:0] counter_step(
        input logic [COUNTER_BITS-1:0] state,
        input logic                    up
    );
        logic [COUNTER_BITS-1:0] next_state;

        next_state = state;
        if (up && state != COUNTER_BITS'(COUNTER_MAX)) begin
            next_state = state + COUNTER_BITS'(1);
        end else if (!up && state != '0) begin
            next_state = state - COUNTER_BITS'(1);
        end
        return next_state;
    endfunction

    // a resolve with nothing in flight is dropped
    assign pop        = resolve_valid && !stack_empty;
    assign mispredict = pop && (head_predicted != resolve_taken);

    assign simple_guess = head_simple_state[COUNTER_BITS-1];
    assign gshare_guess = head_gshare_state[COUNTER_BITS-1];

    assign update_valid      = pop;
    assign update_simple_idx = head_simple_idx;
    assign update_gshare_idx = head_gshare_idx;

    // both components train from their recorded states
    assign update_simple_state = counter_step(head_simple_state, resolve_taken);
    assign update_gshare_state = counter_step(head_gshare_state, resolve_taken);

    // chooser moves only when the components disagreed
    // up means trust gshare
    always_comb begin
        if (simple_guess != gshare_guess) begin
            update_meta_state = counter_step(head_meta_state, gshare_guess == resolve_taken);
        end else begin
            update_meta_state = head_meta_state;
        end
    end

    // history as it should have been after this branch
    assign repair_history = {head_history[HISTORY_BITS-2:0], resolve_taken};

endmodule

// ==== src/bp_top.sv ====
`timescale 1ns/1ns

module bp_top
    import bp_params_pkg::*;
    import pipe_params_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset,

    input  logic                     fetch_valid,
    input  logic [PC_BITS-1:0]       fetch_pc,
    input  logic [FETCH_WIDTH-1:0]   fetch_is_branch,
    input  logic                     resolve_valid,
    input  logic                     resolve_taken,

    output logic [FETCH_WIDTH-1:0]   predict_taken,
    output logic                     fetch_stall,
    output logic                     mispredict
);

    // predictor to stack
    logic [FETCH_WIDTH-1:0]                     push;
    logic [FETCH_WIDTH-1:0][HISTORY_BITS-1:0]   push_simple_idx;
    logic [FETCH_WIDTH-1:0][HISTORY_BITS-1:0]   push_gshare_idx;
    logic [FETCH_WIDTH-1:0][HISTORY_BITS-1:0]   push_history;
    logic [FETCH_WIDTH-1:0][COUNTER_BITS-1:0]   push_simple_state;
    logic [FETCH_WIDTH-1:0][COUNTER_BITS-1:0]   push_gshare_state;
    logic [FETCH_WIDTH-1:0][COUNTER_BITS-1:0]   push_meta_state;
    logic [FETCH_WIDTH-1:0]                     push_predicted;

    // stack to resolver
    logic                      stack_empty;
    logic [HISTORY_BITS-1:0]   head_simple_idx;
    logic [HISTORY_BITS-1:0]   head_gshare_idx;
    logic [HISTORY_BITS-1:0]   head_history;
    logic [COUNTER_BITS-1:0]   head_simple_state;
    logic [COUNTER_BITS-1:0]   head_gshare_state;
    logic [COUNTER_BITS-1:0]   head_meta_state;
    logic                      head_predicted;

    // resolver back to stack and predictor
    logic                      pop;
    logic                      update_valid;
    logic [HISTORY_BITS-1:0]   update_simple_idx;
    logic [HISTORY_BITS-1:0]   update_gshare_idx;
    logic [COUNTER_BITS-1:0]   update_simple_state;
    logic [COUNTER_BITS-1:0]   update_gshare_state;
    logic [COUNTER_BITS-1:0]   update_meta_state;
    logic [HISTORY_BITS-1:0]   repair_history;

    // every port name matches a wire or port here
    branch_predictor predictor (.*);

    branch_stack stack (.*);

    branch_resolver resolver (.*);

endmodule

// ==== testbench/bp_assertions.sv ====
`timescale 1ns/1ns

module bp_assertions
    import pipe_params_pkg::*;
(
    input logic                   clock,
    input logic                   reset,
    input logic                   fetch_stall,
    input logic [FETCH_WIDTH-1:0] push,
    input logic                   pop,
    input logic                   stack_empty,
    input logic                   mispredict
);

    logic violation_seen = 1'b0;   // read by the testbench

    no_push_in_stall: assert property (@(posedge clock) disable iff (reset)
        fetch_stall |-> push == '0)
        else begin
            $error("push while fetch_stall is high");
            violation_seen = 1'b1;
        end

    no_pop_when_empty: assert property (@(posedge clock) disable iff (reset)
        pop |-> !stack_empty)
        else begin
            $error("pop from an empty branch stack");
            violation_seen = 1'b1;
        end

    // flush drops every record, the oldest too
    flush_empties_stack: assert property (@(posedge clock) disable iff (reset)
        mispredict |=> stack_empty)
        else begin
            $error("branch stack not empty after a mispredict");
            violation_seen = 1'b1;
        end

endmodule

bind bp_top bp_assertions checks (
    .clock(clock),
    .reset(reset),
    .fetch_stall(fetch_stall),
    .push(push),
    .pop(pop),
    .stack_empty(stack_empty),
    .mispredict(mispredict)
);

// ==== testbench/bp_tb.sv ====
`timescale 1ns/1ns

module bp_tb
    import bp_params_pkg::*;
    import pipe_params_pkg::*;
();

    localparam int DIRECTED_CYCLES = 170;   // upper bound over the directed tests
    localparam int RANDOM_CYCLES = 400;
    localparam int TIMEOUT_NS = (2 + DIRECTED_CYCLES + RANDOM_CYCLES + 100) * 8;

    logic                   clock;
    logic                   reset;
    logic                   fetch_valid;
    logic [PC_BITS-1:0]     fetch_pc;
    logic [FETCH_WIDTH-1:0] fetch_is_branch;
    logic                   resolve_valid;
    logic                   resolve_taken;
    logic [FETCH_WIDTH-1:0] predict_taken;
    logic                   fetch_stall;
    logic                   mispredict;

    // model of the tables, the history and the in-flight records
    logic [COUNTER_BITS-1:0] ref_simple [PHT_SIZE];
    logic [COUNTER_BITS-1:0] ref_gshare [PHT_SIZE];
    logic [COUNTER_BITS-1:0] ref_meta   [PHT_SIZE];
    logic [HISTORY_BITS-1:0] ref_history;
    // record {simple idx, gshare idx, history, simple, gshare, meta, predicted}
    logic [24:0]             ref_queue [$];

    integer      seed;
    logic [31:0] rnd;

    bp_top dut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        stop_on_error($sformatf("[ERROR] time %0t: %s expected %0h, actual %0h",
                                $time, name, expected, actual));
    endtask

    // one counter step toward the outcome, held at 0 and at the maximum
    function automatic logic [COUNTER_BITS-1:0] saturate_step(
        input logic [COUNTER_BITS-1:0] state,
        input logic                    up
    );
        if (up && state != COUNTER_BITS'(COUNTER_MAX)) return state + COUNTER_BITS'(1);
        if (!up && state != '0) return state - COUNTER_BITS'(1);
        return state;
    endfunction

    function automatic logic [24:0] make_record(input logic [PC_BITS-1:0] pc,
                                                input logic [HISTORY_BITS-1:0] hist);
        logic [HISTORY_BITS-1:0] sidx;
        logic [HISTORY_BITS-1:0] gidx;
        logic [COUNTER_BITS-1:0] s;
        logic [COUNTER_BITS-1:0] g;
        logic [COUNTER_BITS-1:0] m;
        logic                    pred;

        sidx = pc[INDEX_LSB +: HISTORY_BITS];
        gidx = sidx ^ hist;
        s = ref_simple[sidx];
        g = ref_gshare[gidx];
        m = ref_meta[sidx];
        pred = m[COUNTER_BITS-1] ? g[COUNTER_BITS-1] : s[COUNTER_BITS-1];   // chooser
        return {sidx, gidx, hist, s, g, m, pred};
    endfunction

    function automatic logic [FETCH_WIDTH-1:0] ref_predict(
        input  logic [PC_BITS-1:0]               pc,
        input  logic [FETCH_WIDTH-1:0]           is_branch,
        output logic [FETCH_WIDTH-1:0][24:0]     records,
        output logic [FETCH_WIDTH-1:0]           recorded,
        output logic [HISTORY_BITS-1:0]          group_history
    );
        logic [FETCH_WIDTH-1:0]  taken;
        logic [HISTORY_BITS-1:0] hist;
        logic                    blocked;

        hist = ref_history;
        blocked = 1'b0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            records[i] = make_record(pc + PC_BITS'(4 * i), hist);
            recorded[i] = is_branch[i] && !blocked;
            taken[i] = recorded[i] && records[i][0];
            if (recorded[i]) hist = {hist[HISTORY_BITS-2:0], records[i][0]};
            blocked = blocked || taken[i];   // younger slots are off-path
        end
        group_history = hist;
        return taken;
    endfunction

    task automatic model_reset();
        for (int e = 0; e < PHT_SIZE; e++) begin
            ref_simple[e] = '0;
            ref_gshare[e] = '0;
            ref_meta[e] = '0;
        end
        ref_history = '0;
        ref_queue.delete();
    endtask

    // state after the coming edge, from the inputs of this cycle
    task automatic model_step(input logic stall, input logic flush,
                              input logic [FETCH_WIDTH-1:0][24:0] records,
                              input logic [FETCH_WIDTH-1:0] recorded,
                              input logic [HISTORY_BITS-1:0] group_history);
        logic [24:0]             head;
        logic [COUNTER_BITS-1:0] s;
        logic [COUNTER_BITS-1:0] g;
        logic [COUNTER_BITS-1:0] m;

        head = '0;
        if (resolve_valid && ref_queue.size() != 0) begin
            head = ref_queue.pop_front();
            s = head[6:5];
            g = head[4:3];
            m = head[2:1];
            ref_simple[head[24:19]] = saturate_step(s, resolve_taken);
            ref_gshare[head[18:13]] = saturate_step(g, resolve_taken);
            if (s[COUNTER_BITS-1] != g[COUNTER_BITS-1]) begin
                ref_meta[head[24:19]] = saturate_step(m, g[COUNTER_BITS-1] == resolve_taken);
            end else begin
                ref_meta[head[24:19]] = m;   // recorded value goes back unchanged
            end
        end
        if (flush) begin
            ref_queue.delete();
            ref_history = {head[11:7], resolve_taken};
        end else if (fetch_valid && !stall) begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (recorded[i]) ref_queue.push_back(records[i]);
            end
            ref_history = group_history;
        end
    endtask

    always @(negedge clock) begin : compare
        logic [FETCH_WIDTH-1:0]       exp_taken;
        logic [FETCH_WIDTH-1:0][24:0] records;
        logic [FETCH_WIDTH-1:0]       recorded;
        logic [HISTORY_BITS-1:0]      group_history;
        logic                         exp_stall;
        logic                         exp_mispredict;

        if (reset !== 1'b0) begin
            model_reset();
        end else begin
            exp_taken = ref_predict(fetch_pc, fetch_is_branch, records, recorded, group_history);
            exp_stall = ref_queue.size() > STACK_DEPTH - FETCH_WIDTH;
            exp_mispredict = 1'b0;
            if (resolve_valid && ref_queue.size() != 0) begin
                exp_mispredict = ref_queue[0][0] != resolve_taken;
            end
            assert (predict_taken === exp_taken)
                else report_value("predict_taken", 32'(exp_taken), 32'(predict_taken));
            assert (fetch_stall === exp_stall)
                else report_value("fetch_stall", 32'(exp_stall), 32'(fetch_stall));
            assert (mispredict === exp_mispredict)
                else report_value("mispredict", 32'(exp_mispredict), 32'(mispredict));
            assert (!dut.checks.violation_seen)
                else stop_on_error("a concurrent assertion bound into bp_top failed");
            model_step(exp_stall, exp_mispredict, records, recorded, group_history);
        end
    end

    task automatic step_to_drive();
        @(posedge clock);
        #1;
    endtask

    task automatic set_inputs(input logic fv, input logic [PC_BITS-1:0] pc,
                              input logic [FETCH_WIDTH-1:0] br, input logic rv, input logic rt);
        fetch_valid = fv;
        fetch_pc = pc;
        fetch_is_branch = br;
        resolve_valid = rv;
        resolve_taken = rt;
    endtask

    task automatic drive(input logic fv, input logic [PC_BITS-1:0] pc,
                         input logic [FETCH_WIDTH-1:0] br, input logic rv, input logic rt);
        step_to_drive();
        set_inputs(fv, pc, br, rv, rt);
    endtask

    // resolve everything in flight, either as predicted or alternating
    task automatic drain(input logic follow_prediction);
        int n;

        n = 0;
        forever begin
            step_to_drive();
            if (ref_queue.size() == 0) begin
                set_inputs(1'b0, '0, '0, 1'b0, 1'b0);
                break;
            end
            set_inputs(1'b0, '0, '0, 1'b1, follow_prediction ? ref_queue[0][0] : !n[0]);
            n++;
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        stop_on_error($sformatf("timeout: the tests did not finish within %0d ns", TIMEOUT_NS));
    end

    initial begin
        seed = 32'hc35d;
        reset = 1'b1;
        set_inputs(1'b0, '0, '0, 1'b0, 1'b0);
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        // fresh tables predict not taken everywhere
        for (int i = 0; i < 4; i++) begin
            drive(1'b0, PC_BITS'(32'h40 * i), '1, 1'b0, 1'b0);
            #2;
            assert (predict_taken == '0)
                else report_value("predict_taken", 32'h0, 32'(predict_taken));
            assert (!fetch_stall)
                else report_value("fetch_stall", 32'h0, 32'(fetch_stall));
            assert (!mispredict)
                else report_value("mispredict", 32'h0, 32'(mispredict));
        end

        // always-taken branch trains the simple table
        for (int i = 0; i < 6; i++) begin
            drive(1'b1, 32'h104, 2'b01, 1'b0, 1'b0);
            drive(1'b0, '0, '0, 1'b1, 1'b1);
        end
        drive(1'b0, 32'h104, 2'b01, 1'b0, 1'b0);
        #2;
        assert (predict_taken[0])
            else report_value("predict_taken[0]", 32'h1, 32'(predict_taken[0]));

        // alternating branch, gshare should win the chooser
        for (int i = 0; i < 40; i++) begin
            drive(1'b1, 32'h208, 2'b01, 1'b0, 1'b0);
            drive(1'b0, '0, '0, 1'b1, !i[0]);
            #2;
            if (i >= 32) begin
                assert (!mispredict)
                    else report_value("mispredict", 32'h0, 32'(mispredict));
            end
        end

        // two-branch groups, a taken slot 0 hides slot 1
        for (int i = 0; i < 6; i++) begin
            drive(1'b1, (i < 2) ? 32'h104 : PC_BITS'(32'h300 + 8 * i), '1, 1'b0, 1'b0);
            if (i == 0) begin
                #2;
                assert (predict_taken == 2'b01)
                    else report_value("predict_taken", 32'h1, 32'(predict_taken));
            end
            drain(1'b0);
        end

        // fill the stack until the stall holds fetch off
        for (int i = 0; i < 9; i++) begin
            drive(1'b1, 32'h4a0, '1, 1'b0, 1'b0);
        end
        #2;
        assert (fetch_stall)
            else report_value("fetch_stall", 32'h1, 32'(fetch_stall));
        for (int i = 0; i < 2; i++) begin
            step_to_drive();
            set_inputs(1'b0, '0, '0, 1'b1, ref_queue[0][0]);
        end
        drive(1'b0, '0, '0, 1'b0, 1'b0);
        #2;
        assert (!fetch_stall)
            else report_value("fetch_stall", 32'h0, 32'(fetch_stall));
        drain(1'b1);

        // random mix of fetches and resolutions
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            step_to_drive();
            rnd = $random(seed);
            set_inputs(rnd[0], {24'h0, rnd[9:4], 2'b00}, rnd[11:10], rnd[12], rnd[14]);
        end
        drain(1'b1);

        repeat (2) @(posedge clock);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== all.f ====
common/bp_params_pkg.sv
common/pipe_params_pkg.sv
branch_predictor/branch_predictor.sv
src/branch_stack.sv
src/branch_resolver.sv
src/bp_top.sv
testbench/bp_assertions.sv
testbench/bp_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module bp_tb -f all.f -o bp_sim
./obj_dir/bp_sim 2>&1 | tee sim.log

if grep -qF '*** FAILED ***' sim.log || ! grep -qF '*** PASSED ***' sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
